// File: verilog/proc_params.svh
// Opcode, function code and reset macros shared by the processor RTL and its testbench
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// 5-bit opcodes
`define OP_HALT 5'b00000
`define OP_ADDI 5'b01000
`define OP_BEQZ 5'b01100
`define OP_BNEZ 5'b01101
`define OP_ST   5'b10000
`define OP_LD   5'b10001
`define OP_LBI  5'b11000
`define OP_ADDR 5'b11011 // Register ops, func picks the operation

// Function codes for OP_ADDR
`define FN_ADD 2'b00
`define FN_SUB 2'b01 // rs - rt
`define FN_XOR 2'b10
`define FN_AND 2'b11

`define NUM_REGS 8
`define RESET_PC 16'h0000

`endif

// File: verilog/proc_pkg.sv
// Instruction word type with its register and immediate views, used by fetch and decode
package proc_pkg;

   // Register form: rd <= rs func rt
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } r_fmt_t;

   // Short immediate form for ADDI, LD and ST
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [4:0] imm5;
   } i5_fmt_t;

   // Long immediate form for branches and LBI
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [7:0] imm8;
   } i8_fmt_t;

   // Same 16 bits, read through whichever view the opcode calls for
   typedef union packed {
      r_fmt_t  r;
      i5_fmt_t i5;
      i8_fmt_t i8;
   } instr_t;

endpackage

// File: verilog/fetch_stage.sv
// Fetch stage holding the PC and the fetch/decode register, fed by a combinational instruction port
`timescale 1ns/1ps
`include "proc_params.svh"

module fetch_stage (
   input  logic             clk,
   input  logic             reset,
   input  logic             stall,
   input  logic             flush,
   input  logic             halted,
   input  logic             branch_taken,
   input  logic [15:0]      branch_target,
   input  logic [15:0]      imem_data,
   output logic [15:0]      imem_addr,
   output proc_pkg::instr_t instr,
   output logic [15:0]      pc_next,
   output logic             valid_d
);

   logic [15:0] pc;
   logic [15:0] pc_plus2;

   assign pc_plus2  = pc + 16'd2;
   assign imem_addr = pc; // ROM answers in the same cycle

   // Program counter, frozen for good once halted
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `RESET_PC;
      end else if (!stall && !halted) begin
         pc <= branch_taken ? branch_target : pc_plus2;
      end
   end

   // Fetch/decode register
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_d <= 1'b0;
      end else if (!stall) begin
         valid_d <= !flush && !halted; // Wrong-path word becomes a bubble
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         instr   <= imem_data;
         pc_next <= pc_plus2;
      end
   end

   // Branch offsets are scaled by two in decode, so no path can make the PC odd
   pc_even_a: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

// File: verilog/decode_stage.sv
// Decode stage with control decode, register file, hazard check and the decode/execute register
`timescale 1ns/1ps
`include "proc_params.svh"

module decode_stage (
   input  logic             clk,
   input  logic             reset,
   input  logic             stall_mem,
   input  logic             flush,
   input  proc_pkg::instr_t instr,
   input  logic [15:0]      pc_next,
   input  logic             valid_d,
   input  logic             wb_wen,
   input  logic [2:0]       wb_dest,
   input  logic [15:0]      wb_value,
   input  logic [2:0]       wdest_m,
   input  logic             reg_write_m,
   output logic             stall_hazard,
   output logic [15:0]      op_a,
   output logic [15:0]      op_b,
   output logic [15:0]      store_data,
   output logic [2:0]       wdest,
   output logic [1:0]       alu_func,
   output logic             reg_write_e,
   output logic             mem_read_e,
   output logic             mem_write_e,
   output logic             is_halt_e,
   output logic             is_beqz_e,
   output logic             is_bnez_e,
   output logic [15:0]      branch_target,
   output logic             valid_e,
   output logic             err
);

   logic [4:0]  opcode;
   logic [2:0]  rs, rt, dest;
   logic        is_r, is_addi, is_ld, is_st, is_beqz, is_bnez, is_lbi, is_halt;
   logic        legal, uses_rs, uses_rt, dec_reg_write, bubble;
   logic        haz_e, haz_m;
   logic [15:0] rs_val, rt_val, imm5_ext, imm8_ext;
   logic [15:0] regs [`NUM_REGS];

   assign opcode = instr.r.opcode;
   assign rs     = instr.r.rs;
   assign rt     = instr.r.rt;

   assign is_r    = opcode == `OP_ADDR;
   assign is_addi = opcode == `OP_ADDI;
   assign is_ld   = opcode == `OP_LD;
   assign is_st   = opcode == `OP_ST;
   assign is_beqz = opcode == `OP_BEQZ;
   assign is_bnez = opcode == `OP_BNEZ;
   assign is_lbi  = opcode == `OP_LBI;
   assign is_halt = opcode == `OP_HALT;
   assign legal   = is_r || is_addi || is_ld || is_st || is_beqz || is_bnez || is_lbi || is_halt;

   assign uses_rs       = is_r || is_addi || is_ld || is_st || is_beqz || is_bnez;
   assign uses_rt       = is_r || is_st; // ST data comes from rt
   assign dec_reg_write = is_r || is_addi || is_ld || is_lbi;
   assign dest          = is_r ? instr.r.rd : (is_lbi ? rs : instr.i5.rt);

   assign imm5_ext = {{11{instr.i5.imm5[4]}}, instr.i5.imm5};
   assign imm8_ext = {{8{instr.i8.imm8[7]}}, instr.i8.imm8};

   // Register file written by writeback and bypassed to the read ports
   always_ff @(posedge clk) begin
      if (wb_wen) begin
         regs[wb_dest] <= wb_value;
      end
   end

   assign rs_val = (wb_wen && wb_dest == rs) ? wb_value : regs[rs];
   assign rt_val = (wb_wen && wb_dest == rt) ? wb_value : regs[rt];

   // Execute's pending write sits in our own output register
   assign haz_e = reg_write_e && ((uses_rs && wdest == rs) || (uses_rt && wdest == rt));
   assign haz_m = reg_write_m && ((uses_rs && wdest_m == rs) || (uses_rt && wdest_m == rt));
   assign stall_hazard = valid_d && (haz_e || haz_m);

   assign bubble = !valid_d || stall_hazard || flush;

   // Decode/execute control cleared for a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_e     <= 1'b0;
         reg_write_e <= 1'b0;
         mem_read_e  <= 1'b0;
         mem_write_e <= 1'b0;
         is_halt_e   <= 1'b0;
         is_beqz_e   <= 1'b0;
         is_bnez_e   <= 1'b0;
      end else if (!stall_mem) begin
         valid_e     <= !bubble;
         reg_write_e <= !bubble && dec_reg_write;
         mem_read_e  <= !bubble && is_ld;
         mem_write_e <= !bubble && is_st;
         is_halt_e   <= !bubble && is_halt;
         is_beqz_e   <= !bubble && is_beqz;
         is_bnez_e   <= !bubble && is_bnez;
      end
   end

   // Operands and branch target
   always_ff @(posedge clk) begin
      if (!stall_mem) begin
         op_a          <= is_lbi ? 16'h0000 : rs_val; // LBI goes through the adder as 0 + imm
         op_b          <= is_r ? rt_val : (is_lbi ? imm8_ext : imm5_ext);
         store_data    <= rt_val;
         wdest         <= dest;
         alu_func      <= is_r ? instr.r.func : `FN_ADD;
         branch_target <= pc_next + {imm8_ext[14:0], 1'b0}; // Offset counts instructions
      end
   end

   // Sticky error flag that ignores wrong-path words
   always_ff @(posedge clk) begin
      if (reset) begin
         err <= 1'b0;
      end else if (valid_d && !flush && !legal) begin
         err <= 1'b1;
      end
   end

   // A held instruction stays in the fetch/decode register until its source is written
   hazard_hold_a: assert property (@(posedge clk) disable iff (reset)
      (stall_hazard && !flush) |=> valid_d && $stable(instr));

endmodule

// File: verilog/execute_stage.sv
// Execute stage with the ALU, branch resolution and the execute/memory register
`timescale 1ns/1ps
`include "proc_params.svh"

module execute_stage (
   input  logic        clk,
   input  logic        reset,
   input  logic        stall,
   input  logic [15:0] op_a,
   input  logic [15:0] op_b,
   input  logic [15:0] store_data,
   input  logic [2:0]  wdest,
   input  logic [1:0]  alu_func,
   input  logic        reg_write_e,
   input  logic        mem_read_e,
   input  logic        mem_write_e,
   input  logic        is_halt_e,
   input  logic        is_beqz_e,
   input  logic        is_bnez_e,
   input  logic [15:0] branch_target,
   input  logic        valid_e,
   output logic        branch_taken,
   output logic [15:0] alu_result,
   output logic [15:0] store_data_m,
   output logic [2:0]  wdest_m,
   output logic        reg_write_m,
   output logic        mem_read_m,
   output logic        mem_write_m,
   output logic        is_halt_m,
   output logic        valid_m
);

   logic [15:0] alu_out;
   logic        a_zero;

   // ADDI, LD/ST address and LBI all arrive with the add code
   always_comb begin
      case (alu_func)
         `FN_SUB: alu_out = op_a - op_b;
         `FN_AND: alu_out = op_a & op_b;
         `FN_XOR: alu_out = op_a ^ op_b;
         default: alu_out = op_a + op_b;
      endcase
   end

   assign a_zero       = op_a == 16'h0000;
   assign branch_taken = valid_e && ((is_beqz_e && a_zero) || (is_bnez_e && !a_zero));

   // Execute/memory control
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_m     <= 1'b0;
         reg_write_m <= 1'b0;
         mem_read_m  <= 1'b0;
         mem_write_m <= 1'b0;
         is_halt_m   <= 1'b0;
      end else if (!stall) begin
         valid_m     <= valid_e;
         reg_write_m <= reg_write_e; // Already cleared for bubbles
         mem_read_m  <= mem_read_e;
         mem_write_m <= mem_write_e;
         is_halt_m   <= is_halt_e;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         alu_result   <= alu_out;
         store_data_m <= store_data;
         wdest_m      <= wdest;
      end
   end

   // Decode sets at most one branch kind per instruction
   one_branch_a: assert property (@(posedge clk) disable iff (reset)
      !(is_beqz_e && is_bnez_e));

   // Target handed to fetch is a whole instruction away
   target_even_a: assert property (@(posedge clk) disable iff (reset)
      branch_taken |-> branch_target[0] == 1'b0);

endmodule

// File: verilog/memory_stage.sv
// Memory stage acting as Wishbone classic master, with the writeback register and halt latch
`timescale 1ns/1ps

module memory_stage (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] alu_result,
   input  logic [15:0] store_data_m,
   input  logic [2:0]  wdest_m,
   input  logic        reg_write_m,
   input  logic        mem_read_m,
   input  logic        mem_write_m,
   input  logic        is_halt_m,
   input  logic        valid_m,
   input  logic [15:0] wb_dat_r,
   input  logic        wb_ack,
   output logic        wb_cyc,
   output logic        wb_stb,
   output logic        wb_we,
   output logic [15:0] wb_adr,
   output logic [15:0] wb_dat_w,
   output logic        stall_mem,
   output logic        wb_wen,
   output logic [2:0]  wb_dest,
   output logic [15:0] wb_value,
   output logic        halted
);

   logic mem_req;

   assign mem_req   = valid_m && (mem_read_m || mem_write_m) && !halted;
   assign stall_mem = mem_req && !(wb_cyc && wb_ack); // Held until the ack edge

   // Execute/memory register is frozen while we wait, so these stay put
   assign wb_adr   = alu_result;
   assign wb_dat_w = store_data_m;
   assign wb_we    = mem_write_m;

   // Bus cycle: start on a request, end the cycle after ack
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_cyc <= 1'b0;
         wb_stb <= 1'b0;
      end else if (wb_cyc) begin
         if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
         end
      end else if (mem_req) begin
         wb_cyc <= 1'b1;
         wb_stb <= 1'b1;
      end
   end

   // Writeback register, load data taken on the ack
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_wen <= 1'b0;
      end else if (!stall_mem) begin
         wb_wen <= valid_m && reg_write_m && !halted;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_mem) begin
         wb_dest  <= wdest_m;
         wb_value <= mem_read_m ? wb_dat_r : alu_result;
      end
   end

   // Halt latch
   always_ff @(posedge clk) begin
      if (reset) begin
         halted <= 1'b0;
      end else if (valid_m && is_halt_m) begin
         halted <= 1'b1;
      end
   end

   stb_in_cyc_a: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc);

   // Relies on the whole pipeline freezing under stall_mem
   bus_stable_a: assert property (@(posedge clk) disable iff (reset)
      (wb_cyc && !wb_ack) |=> wb_cyc && $stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_we));

endmodule

// File: verilog/proc.sv
// Top level of the five-stage processor, wiring the stages with their stall and flush lines
`timescale 1ns/1ps

module proc (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] imem_data,
   input  logic [15:0] wb_dat_r,
   input  logic        wb_ack,
   output logic [15:0] imem_addr,
   output logic        wb_cyc,
   output logic        wb_stb,
   output logic        wb_we,
   output logic [15:0] wb_adr,
   output logic [15:0] wb_dat_w,
   output logic        halted,
   output logic        err
);

   // Fetch to decode
   proc_pkg::instr_t instr;
   logic [15:0]      pc_next;
   logic             valid_d;

   // Decode to execute
   logic [15:0] op_a, op_b, store_data, branch_target;
   logic [2:0]  wdest;
   logic [1:0]  alu_func;
   logic        reg_write_e, mem_read_e, mem_write_e, is_halt_e;
   logic        is_beqz_e, is_bnez_e, valid_e;

   // Execute to memory
   logic [15:0] alu_result, store_data_m;
   logic [2:0]  wdest_m;
   logic        reg_write_m, mem_read_m, mem_write_m, is_halt_m, valid_m;

   // Writeback and control
   logic        wb_wen;
   logic [2:0]  wb_dest;
   logic [15:0] wb_value;
   logic        stall_mem, stall_hazard, branch_taken, fetch_stall;

   // A taken branch overrides a hazard hold, a bus wait overrides both
   assign fetch_stall = stall_mem || (stall_hazard && !branch_taken);

   fetch_stage i_fetch (
      .clk(clk), .reset(reset), .stall(fetch_stall), .flush(branch_taken),
      .halted(halted), .branch_taken(branch_taken), .branch_target(branch_target),
      .imem_data(imem_data), .imem_addr(imem_addr), .instr(instr),
      .pc_next(pc_next), .valid_d(valid_d));

   decode_stage i_decode (
      .clk(clk), .reset(reset), .stall_mem(stall_mem), .flush(branch_taken),
      .instr(instr), .pc_next(pc_next), .valid_d(valid_d),
      .wb_wen(wb_wen), .wb_dest(wb_dest), .wb_value(wb_value),
      .wdest_m(wdest_m), .reg_write_m(reg_write_m), .stall_hazard(stall_hazard),
      .op_a(op_a), .op_b(op_b), .store_data(store_data), .wdest(wdest),
      .alu_func(alu_func), .reg_write_e(reg_write_e), .mem_read_e(mem_read_e),
      .mem_write_e(mem_write_e), .is_halt_e(is_halt_e), .is_beqz_e(is_beqz_e),
      .is_bnez_e(is_bnez_e), .branch_target(branch_target), .valid_e(valid_e),
      .err(err));

   execute_stage i_execute (
      .clk(clk), .reset(reset), .stall(stall_mem), .op_a(op_a), .op_b(op_b),
      .store_data(store_data), .wdest(wdest), .alu_func(alu_func),
      .reg_write_e(reg_write_e), .mem_read_e(mem_read_e), .mem_write_e(mem_write_e),
      .is_halt_e(is_halt_e), .is_beqz_e(is_beqz_e), .is_bnez_e(is_bnez_e),
      .branch_target(branch_target), .valid_e(valid_e), .branch_taken(branch_taken),
      .alu_result(alu_result), .store_data_m(store_data_m), .wdest_m(wdest_m),
      .reg_write_m(reg_write_m), .mem_read_m(mem_read_m), .mem_write_m(mem_write_m),
      .is_halt_m(is_halt_m), .valid_m(valid_m));

   memory_stage i_memory (
      .clk(clk), .reset(reset), .alu_result(alu_result), .store_data_m(store_data_m),
      .wdest_m(wdest_m), .reg_write_m(reg_write_m), .mem_read_m(mem_read_m),
      .mem_write_m(mem_write_m), .is_halt_m(is_halt_m), .valid_m(valid_m),
      .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
      .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .stall_mem(stall_mem),
      .wb_wen(wb_wen), .wb_dest(wb_dest), .wb_value(wb_value), .halted(halted));

endmodule

// File: sim/tb_memory.sv
// Testbench memory model: combinational instruction ROM and a Wishbone classic data slave
`timescale 1ns/1ps

module tb_memory (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] imem_addr,
   output logic [15:0] imem_data,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [15:0] wb_adr,
   input  logic [15:0] wb_dat_w,
   output logic [15:0] wb_dat_r,
   output logic        wb_ack,
   output logic        st_seen,
   output logic [15:0] st_adr,
   output logic [15:0] st_dat
);

   logic [15:0] rom [64];
   logic [15:0] dmem [256];
   logic [31:0] lcg_state = 32'd3;
   logic        busy;
   int          wait_cnt;

   assign imem_data = rom[imem_addr[6:1]];

   // Ack delay of 1 to 4 cycles
   function automatic int next_delay();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'(lcg_state[17:16]) + 1;
   endfunction

   task automatic clear_rom();
      for (int i = 0; i < 64; i++) rom[i] = 16'h0000; // HALT everywhere
   endtask

   task automatic write_rom(input int idx, input logic [15:0] word);
      rom[idx] = word;
   endtask

   task automatic init_data();
      logic [7:0] a;
      for (int i = 0; i < 256; i++) begin
         a = 8'(i);
         dmem[i] = {~a, a};
      end
   endtask

   // Slave side, driven on the falling edge
   always @(negedge clk) begin
      if (reset) begin
         wb_ack  <= 1'b0;
         st_seen <= 1'b0;
         busy     = 1'b0;
      end else if (wb_ack) begin
         wb_ack  <= 1'b0;
         st_seen <= 1'b0;
         busy     = 1'b0;
      end else if (wb_cyc && wb_stb) begin
         if (!busy) begin
            busy     = 1'b1;
            wait_cnt = next_delay();
         end
         wait_cnt--;
         if (wait_cnt == 0) begin
            wb_ack <= 1'b1;
            if (wb_we) begin
               dmem[wb_adr[7:0]] = wb_dat_w;
               st_seen <= 1'b1;
               st_adr  <= wb_adr;
               st_dat  <= wb_dat_w;
            end else begin
               wb_dat_r <= dmem[wb_adr[7:0]];
            end
         end
      end
   end

endmodule

// File: sim/proc_tb.sv
// Testbench for the pipelined processor that runs small programs and checks stores against an ISA model
`timescale 1ns/1ps
`include "proc_params.svh"

module proc_tb;

   logic        clk;
   logic        reset;
   logic [15:0] imem_addr, imem_data, wb_adr, wb_dat_w, wb_dat_r, st_adr, st_dat;
   logic        wb_cyc, wb_stb, wb_we, wb_ack, halted, err, st_seen;

   logic [15:0] prog [64];
   int          plen;
   logic [31:0] exp_q [$];
   logic [31:0] exp_pair;
   logic        exp_err;
   int          errors = 0;
   int          tests = 0;
   int          stores = 0;
   int          cycles = 0;
   int          limit = 200;

   proc i_dut (
      .clk(clk), .reset(reset), .imem_data(imem_data), .wb_dat_r(wb_dat_r),
      .wb_ack(wb_ack), .imem_addr(imem_addr), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
      .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .halted(halted), .err(err));

   tb_memory i_mem (
      .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .st_seen(st_seen), .st_adr(st_adr), .st_dat(st_dat));

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Timeout
   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, the DUT never halted", cycles);
         $display("Errors found");
         $finish;
      end
   end

   // Each store must be the next one the ISA model predicts
   always @(posedge clk) begin
      if (!reset && st_seen) begin
         stores++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected store of %h to %h at %0t", st_dat, st_adr, $time);
         end else begin
            exp_pair = exp_q.pop_front();
            assert ({st_adr, st_dat} == exp_pair) else begin
               errors++;
               $display("Mismatch at %0t: store %h to %h, expected %h to %h",
                        $time, st_dat, st_adr, exp_pair[15:0], exp_pair[31:16]);
            end
         end
      end
   end

   bus_hold_a: assert property (@(posedge clk) disable iff (reset)
      (wb_cyc && !wb_ack) |=> wb_cyc && wb_stb && $stable(wb_we) && $stable(wb_adr)
         && $stable(wb_dat_w)) else begin
      errors++;
      $display("Bus cycle dropped or changed before ack at %0t", $time);
   end

   halt_final_a: assert property (@(posedge clk) disable iff (reset)
      halted |=> halted && !wb_cyc) else begin
      errors++;
      $display("Bus cycle or halt drop after HALT at %0t", $time);
   end

   function automatic logic [15:0] enc_r(input logic [1:0] fn, input int rd, rs, rt);
      return {`OP_ADDR, 3'(rs), 3'(rt), 3'(rd), fn};
   endfunction

   function automatic logic [15:0] enc_i5(input logic [4:0] op, input int rt, rs, imm);
      return {op, 3'(rs), 3'(rt), imm[4:0]};
   endfunction

   function automatic logic [15:0] enc_i8(input logic [4:0] op, input int rs, imm);
      return {op, 3'(rs), imm[7:0]};
   endfunction

   task automatic emit(input logic [15:0] word);
      prog[plen] = word;
      plen++;
   endtask

   // ISA reference model that walks the program and queues every store
   task automatic run_model();
      logic [15:0] r [8];
      logic [15:0] dm [256];
      logic [15:0] w, i5, i8, a;
      logic [7:0]  b;
      int          pc, nxt, steps;
      bit          done;
      for (int i = 0; i < 256; i++) begin
         b = 8'(i);
         dm[i] = {~b, b};
      end
      pc = 0;
      steps = 0;
      done = 0;
      exp_err = 1'b0;
      while (!done && steps < 200) begin
         w = (pc < plen) ? prog[pc] : 16'h0000;
         i5 = {{11{w[4]}}, w[4:0]};
         i8 = {{8{w[7]}}, w[7:0]};
         nxt = pc + 1;
         case (w[15:11])
            `OP_ADDR: case (w[1:0])
               `FN_ADD: r[w[4:2]] = r[w[10:8]] + r[w[7:5]];
               `FN_SUB: r[w[4:2]] = r[w[10:8]] - r[w[7:5]];
               `FN_AND: r[w[4:2]] = r[w[10:8]] & r[w[7:5]];
               default: r[w[4:2]] = r[w[10:8]] ^ r[w[7:5]];
            endcase
            `OP_ADDI: r[w[7:5]] = r[w[10:8]] + i5;
            `OP_LD: begin
               a = r[w[10:8]] + i5;
               r[w[7:5]] = dm[a[7:0]];
            end
            `OP_ST: begin
               a = r[w[10:8]] + i5;
               dm[a[7:0]] = r[w[7:5]];
               exp_q.push_back({a, r[w[7:5]]});
            end
            `OP_BEQZ: if (r[w[10:8]] == 16'h0000) nxt = pc + 1 + $signed(w[7:0]);
            `OP_BNEZ: if (r[w[10:8]] != 16'h0000) nxt = pc + 1 + $signed(w[7:0]);
            `OP_LBI:  r[w[10:8]] = i8;
            `OP_HALT: done = 1;
            default:  exp_err = 1'b1; // Undefined opcode acts as a no-op
         endcase
         pc = nxt;
         steps++;
      end
   endtask

   task automatic run_test(input string name);
      int errors_before, stores_before;
      errors_before = errors;
      stores_before = stores;
      exp_q.delete();
      run_model();
      limit += 10 * plen;
      @(negedge clk);
      reset = 1'b1;
      i_mem.clear_rom();
      for (int i = 0; i < plen; i++) i_mem.write_rom(i, prog[i]);
      i_mem.init_data();
      repeat (16) @(negedge clk);
      reset = 1'b0;
      while (!halted) @(negedge clk);
      repeat (4) @(negedge clk);
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("Test %s ended with %0d expected stores missing", name, exp_q.size());
      end
      assert (err == exp_err) else begin
         errors++;
         $display("Mismatch at %0t: err is %b, expected %b", $time, err, exp_err);
      end
      tests++;
      $display("Test %s: %0d stores, %0d errors", name, stores - stores_before,
               errors - errors_before);
      plen = 0;
   endtask

   task automatic dep_chain(input int gap);
      emit(enc_i8(`OP_LBI, 1, 5));
      repeat (gap) emit(enc_i8(`OP_LBI, 6, 0));
      emit(enc_i5(`OP_ADDI, 2, 1, 3));
      repeat (gap) emit(enc_i8(`OP_LBI, 6, 0));
      emit(enc_r(`FN_ADD, 3, 2, 1));
      repeat (gap) emit(enc_i8(`OP_LBI, 6, 0));
      emit(enc_r(`FN_SUB, 4, 3, 2));
      repeat (gap) emit(enc_i8(`OP_LBI, 6, 0));
      emit(enc_r(`FN_XOR, 5, 4, 3));
      emit(enc_i8(`OP_LBI, 0, 8'h60));
      repeat (gap) emit(enc_i8(`OP_LBI, 6, 0));
      emit(enc_i5(`OP_ST, 5, 0, 0));
      emit(enc_i5(`OP_ST, 4, 0, 2));
      emit(16'h0000);
   endtask

   initial begin
      reset = 1'b1;
      plen = 0;
      // ALU results
      emit(enc_i8(`OP_LBI, 1, 8'h35));
      emit(enc_i8(`OP_LBI, 2, 8'hF9));
      emit(enc_r(`FN_ADD, 3, 1, 2));
      emit(enc_r(`FN_SUB, 4, 1, 2));
      emit(enc_r(`FN_AND, 5, 1, 2));
      emit(enc_r(`FN_XOR, 6, 1, 2));
      emit(enc_i5(`OP_ADDI, 7, 1, -3));
      emit(enc_i8(`OP_LBI, 0, 8'h40));
      for (int k = 1; k < 8; k++) emit(enc_i5(`OP_ST, k, 0, 2 * k - 2));
      emit(16'h0000);
      run_test("alu");
      dep_chain(0);
      run_test("hazard_chain");
      dep_chain(3);
      run_test("hazard_spaced");
      // Loads and stores
      emit(enc_i8(`OP_LBI, 0, 8'h20));
      emit(enc_i8(`OP_LBI, 1, 8'h7B));
      emit(enc_i5(`OP_ST, 1, 0, 0));
      emit(enc_i5(`OP_LD, 2, 0, 0));
      emit(enc_i5(`OP_ADDI, 3, 2, 1));
      emit(enc_i5(`OP_ST, 3, 0, 2));
      emit(enc_i5(`OP_LD, 4, 0, -2));
      emit(enc_i5(`OP_ST, 4, 0, 4));
      emit(enc_i5(`OP_LD, 5, 0, 2));
      emit(enc_i5(`OP_ST, 5, 0, 6));
      emit(16'h0000);
      run_test("load_store");
      // Branches that skip one store slot when taken
      emit(enc_i8(`OP_LBI, 0, 8'h70));
      emit(enc_i8(`OP_LBI, 1, 0));
      emit(enc_i8(`OP_LBI, 2, 9));
      emit(enc_i8(`OP_BEQZ, 1, 1));
      emit(enc_i5(`OP_ST, 2, 0, 0));
      emit(enc_i5(`OP_ST, 2, 0, 2));
      emit(enc_i8(`OP_BNEZ, 1, 1));
      emit(enc_i5(`OP_ST, 2, 0, 4));
      emit(enc_i8(`OP_BNEZ, 2, 1));
      emit(enc_i5(`OP_ST, 1, 0, 6));
      emit(enc_i8(`OP_BEQZ, 2, 1));
      emit(enc_i5(`OP_ST, 2, 0, 8));
      emit(16'h0000);
      run_test("branch");
      // Undefined opcode, and a store behind the HALT that must never reach the bus
      emit(enc_i8(`OP_LBI, 1, 1));
      emit(16'hF800);
      emit(enc_i8(`OP_LBI, 0, 8'h10));
      emit(enc_i5(`OP_ST, 1, 0, 0));
      emit(16'h0000);
      emit(enc_i5(`OP_ST, 1, 0, 2));
      run_test("illegal");
      $display("Totals: %0d tests, %0d stores, %0d errors", tests, stores, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: files.f
+incdir+verilog
verilog/proc_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/proc.sv
sim/tb_memory.sv
sim/proc_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module proc_tb -o proc_sim \
   > build.log 2>&1 && ./obj_dir/proc_sim > sim.log 2>&1 \
   || { echo "Build or simulation failed"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
